// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       := bp_tb
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+verif
hdl/bp_pkg.sv
hdl/hist_fold_hash.sv
hdl/tag_table.sv
hdl/bimodal_table.sv
hdl/tage_predictor.sv
hdl/branch_predictor_top.sv
verif/bp_assert.sv
verif/bp_tb.sv

// ==== hdl/bimodal_table.sv ====
// bimodal base predictor, 2-bit counters read through two stages
`timescale 1ns/1ps
module bimodal_table (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall,
    input  bp_pkg::pc_t pc,
    output logic        base_taken,
    input  logic        upd_valid,
    input  bp_pkg::pc_t upd_pc,
    input  logic        upd_taken
);
    import bp_pkg::*;

    ctr2_t ctr [TBL_DEPTH];
    idx_t  rd_idx;
    idx_t  upd_idx;
    ctr2_t upd_ctr;
    logic  taken_s1;

    assign rd_idx  = pc[IDX_W-1:0];
    assign upd_idx = upd_pc[IDX_W-1:0];

    // saturating step toward the outcome
    always_comb begin
        upd_ctr = ctr[upd_idx];
        if (upd_taken && upd_ctr != 2'b11) begin
            upd_ctr = upd_ctr + 2'd1;
        end else if (!upd_taken && upd_ctr != 2'b00) begin
            upd_ctr = upd_ctr - 2'd1;
        end
    end

    // weakly not-taken out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < TBL_DEPTH; i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (upd_valid) begin
            ctr[upd_idx] <= upd_ctr;
        end
    end

    // first stage matches the tagged table read,
    // second matches the component registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            taken_s1   <= 1'b0;
            base_taken <= 1'b0;
        end else if (!stall) begin
            taken_s1   <= ctr[rd_idx][1];
            base_taken <= taken_s1;
        end
    end

endmodule

// ==== hdl/bp_pkg.sv ====
// branch predictor shared widths, vector types and metadata field layout
package bp_pkg;

    // widths
    localparam int PC_W  = 30;
    localparam int GH_W  = 32;
    localparam int IDX_W = 8;
    localparam int TAG_W = 12;

    // history lengths of the tagged components
    localparam int HIST_LEN_0 = 8;
    localparam int HIST_LEN_1 = 16;
    localparam int HIST_LEN_2 = 32;

    localparam int NUM_COMP  = 3;
    localparam int TBL_DEPTH = 1 << IDX_W;

    // slice counts for the history folds
    localparam int IDX_FOLDS = GH_W / IDX_W;
    localparam int TAG_FOLDS = (GH_W + TAG_W - 1) / TAG_W;

    // tagged entry is {dir, tag, u}
    localparam int TE_W       = 15;
    localparam int TE_U_LSB   = 0;
    localparam int TE_TAG_LSB = 2;
    localparam int TE_DIR_BIT = 14;

    // metadata handed back at resolve time
    localparam int META_W        = 12;
    localparam int META_PRED_LSB = 0;
    localparam int META_U_LSB    = 3;
    localparam int META_PROV_LSB = 9;
    localparam int META_ALT_BIT  = 11;

    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [GH_W-1:0]   ghist_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [1:0]        ctr2_t;
    // 0 base, 1..3 the 8/16/32 bit components
    typedef logic [1:0]        provider_t;
    typedef logic [META_W-1:0] meta_t;

endpackage

// ==== hdl/branch_predictor_top.sv ====
// branch direction predictor top, bimodal base plus three tagged components
`timescale 1ns/1ps
module branch_predictor_top (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  bp_pkg::pc_t    pc,
    input  bp_pkg::ghist_t gh,
    output logic           pred_taken,
    output bp_pkg::meta_t  pred_meta,
    input  logic           upd_valid,
    input  bp_pkg::pc_t    upd_pc,
    input  bp_pkg::ghist_t upd_gh,
    input  logic           upd_taken,
    input  logic           upd_pred_taken,
    input  bp_pkg::meta_t  upd_meta
);
    import bp_pkg::*;

    idx_t            look_idx0, look_idx1, look_idx2;
    tag_t            look_tag0, look_tag1, look_tag2;
    idx_t            upd_idx0, upd_idx1, upd_idx2;
    tag_t            upd_tag0, upd_tag1, upd_tag2;
    logic [TE_W-1:0] rdata0, rdata1, rdata2;
    logic            rvalid0, rvalid1, rvalid2;
    logic            we0, we1, we2;
    logic [TE_W-1:0] wdata0, wdata1, wdata2;
    logic            base_taken;

    hist_fold_hash look_hash (
        .pc(pc), .gh(gh),
        .idx0(look_idx0), .idx1(look_idx1), .idx2(look_idx2),
        .tag0(look_tag0), .tag1(look_tag1), .tag2(look_tag2)
    );

    hist_fold_hash upd_hash (
        .pc(upd_pc), .gh(upd_gh),
        .idx0(upd_idx0), .idx1(upd_idx1), .idx2(upd_idx2),
        .tag0(upd_tag0), .tag1(upd_tag1), .tag2(upd_tag2)
    );

    // tables read only on unstalled edges
    tag_table tbl0 (
        .clk(clk), .arst_n(arst_n),
        .ren(~stall), .raddr(look_idx0), .rdata(rdata0), .rvalid(rvalid0),
        .we(we0), .waddr(upd_idx0), .wdata(wdata0)
    );

    tag_table tbl1 (
        .clk(clk), .arst_n(arst_n),
        .ren(~stall), .raddr(look_idx1), .rdata(rdata1), .rvalid(rvalid1),
        .we(we1), .waddr(upd_idx1), .wdata(wdata1)
    );

    tag_table tbl2 (
        .clk(clk), .arst_n(arst_n),
        .ren(~stall), .raddr(look_idx2), .rdata(rdata2), .rvalid(rvalid2),
        .we(we2), .waddr(upd_idx2), .wdata(wdata2)
    );

    bimodal_table base_tbl (
        .clk(clk), .arst_n(arst_n), .stall(stall),
        .pc(pc), .base_taken(base_taken),
        .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_taken(upd_taken)
    );

    tage_predictor tage (
        .clk(clk), .arst_n(arst_n), .stall(stall),
        .look_tag0(look_tag0), .look_tag1(look_tag1), .look_tag2(look_tag2),
        .rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2),
        .rvalid0(rvalid0), .rvalid1(rvalid1), .rvalid2(rvalid2),
        .base_taken(base_taken),
        .pred_taken(pred_taken), .pred_meta(pred_meta),
        .upd_valid(upd_valid), .upd_taken(upd_taken),
        .upd_pred_taken(upd_pred_taken), .upd_meta(upd_meta),
        .upd_tag0(upd_tag0), .upd_tag1(upd_tag1), .upd_tag2(upd_tag2),
        .we0(we0), .we1(we1), .we2(we2),
        .wdata0(wdata0), .wdata1(wdata1), .wdata2(wdata2)
    );

endmodule

// ==== hdl/hist_fold_hash.sv ====
// folds pc and global history into index and tag for each tagged component
`timescale 1ns/1ps
module hist_fold_hash (
    input  bp_pkg::pc_t    pc,
    input  bp_pkg::ghist_t gh,
    output bp_pkg::idx_t   idx0,
    output bp_pkg::idx_t   idx1,
    output bp_pkg::idx_t   idx2,
    output bp_pkg::tag_t   tag0,
    output bp_pkg::tag_t   tag1,
    output bp_pkg::tag_t   tag2
);
    import bp_pkg::*;

    ghist_t h0;
    ghist_t h1;
    ghist_t h2;

    // keep only the lowest len history bits
    function automatic ghist_t hist_mask(input int len);
        ghist_t m;
        for (int i = 0; i < GH_W; i++) begin
            m[i] = (i < len);
        end
        return m;
    endfunction

    function automatic idx_t fold_idx(input ghist_t h);
        idx_t r;
        r = '0;
        for (int i = 0; i < IDX_FOLDS; i++) begin
            r = r ^ h[i*IDX_W +: IDX_W];
        end
        return r;
    endfunction

    // top slice is zero padded
    function automatic tag_t fold_tag(input ghist_t h);
        logic [TAG_FOLDS*TAG_W-1:0] ext;
        tag_t r;
        ext = {{(TAG_FOLDS*TAG_W-GH_W){1'b0}}, h};
        r = '0;
        for (int i = 0; i < TAG_FOLDS; i++) begin
            r = r ^ ext[i*TAG_W +: TAG_W];
        end
        return r;
    endfunction

    assign h0 = gh & hist_mask(HIST_LEN_0);
    assign h1 = gh & hist_mask(HIST_LEN_1);
    assign h2 = gh & hist_mask(HIST_LEN_2);

    assign idx0 = pc[IDX_W-1:0] ^ fold_idx(h0);
    assign idx1 = pc[IDX_W-1:0] ^ fold_idx(h1);
    assign idx2 = pc[IDX_W-1:0] ^ fold_idx(h2);

    assign tag0 = pc[IDX_W +: TAG_W] ^ fold_tag(h0);
    assign tag1 = pc[IDX_W +: TAG_W] ^ fold_tag(h1);
    assign tag2 = pc[IDX_W +: TAG_W] ^ fold_tag(h2);

endmodule

// ==== hdl/tag_table.sv ====
// tagged component storage with sync read and per-entry valid bits
`timescale 1ns/1ps
module tag_table (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ren,
    input  bp_pkg::idx_t            raddr,
    output logic [bp_pkg::TE_W-1:0] rdata,
    output logic                    rvalid,
    input  logic                    we,
    input  bp_pkg::idx_t            waddr,
    input  logic [bp_pkg::TE_W-1:0] wdata
);
    import bp_pkg::*;

    logic [TE_W-1:0]      mem [TBL_DEPTH];
    logic [TBL_DEPTH-1:0] valid;

    // same-cycle write to raddr is seen on the next read only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid  <= '0;
            rvalid <= 1'b0;
        end else begin
            if (we) begin
                valid[waddr] <= 1'b1;
            end
            // holds while ren is low
            if (ren) begin
                rvalid <= valid[raddr];
            end
        end
    end

endmodule

// ==== hdl/tage_predictor.sv ====
// tage provider and alternate selection, metadata packing and update policy
`timescale 1ns/1ps
module tage_predictor (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stall,
    input  bp_pkg::tag_t            look_tag0,
    input  bp_pkg::tag_t            look_tag1,
    input  bp_pkg::tag_t            look_tag2,
    input  logic [bp_pkg::TE_W-1:0] rdata0,
    input  logic [bp_pkg::TE_W-1:0] rdata1,
    input  logic [bp_pkg::TE_W-1:0] rdata2,
    input  logic                    rvalid0,
    input  logic                    rvalid1,
    input  logic                    rvalid2,
    input  logic                    base_taken,
    output logic                    pred_taken,
    output bp_pkg::meta_t           pred_meta,
    input  logic                    upd_valid,
    input  logic                    upd_taken,
    input  logic                    upd_pred_taken,
    input  bp_pkg::meta_t           upd_meta,
    input  bp_pkg::tag_t            upd_tag0,
    input  bp_pkg::tag_t            upd_tag1,
    input  bp_pkg::tag_t            upd_tag2,
    output logic                    we0,
    output logic                    we1,
    output logic                    we2,
    output logic [bp_pkg::TE_W-1:0] wdata0,
    output logic [bp_pkg::TE_W-1:0] wdata1,
    output logic [bp_pkg::TE_W-1:0] wdata2
);
    import bp_pkg::*;

    logic [TE_W-1:0]     rd [NUM_COMP];
    logic [NUM_COMP-1:0] rv;
    tag_t                look_tag [NUM_COMP];
    tag_t                look_tag_q [NUM_COMP];
    tag_t                upd_tag [NUM_COMP];

    logic [NUM_COMP-1:0] hit_q;
    logic [NUM_COMP-1:0] pred_q;
    ctr2_t               u_q [NUM_COMP];
    logic [NUM_COMP-1:0] usable;
    provider_t           prov;
    logic                alt_taken;

    // resolve side view of the metadata
    logic [NUM_COMP-1:0] m_pred;
    ctr2_t               m_u [NUM_COMP];
    provider_t           m_prov;
    logic [1:0]          m_slot;
    logic                m_alt;

    logic [NUM_COMP-1:0] we;
    logic [NUM_COMP-1:0] new_dir;
    ctr2_t               new_u [NUM_COMP];

    function automatic ctr2_t sat_step(input ctr2_t c, input logic up);
        ctr2_t r;
        r = c;
        if (up && c != 2'b11) begin
            r = c + 2'd1;
        end else if (!up && c != 2'b00) begin
            r = c - 2'd1;
        end
        return r;
    endfunction

    assign rd[0]       = rdata0;
    assign rd[1]       = rdata1;
    assign rd[2]       = rdata2;
    assign rv          = {rvalid2, rvalid1, rvalid0};
    assign look_tag[0] = look_tag0;
    assign look_tag[1] = look_tag1;
    assign look_tag[2] = look_tag2;
    assign upd_tag[0]  = upd_tag0;
    assign upd_tag[1]  = upd_tag1;
    assign upd_tag[2]  = upd_tag2;

    // tags wait alongside the table read
    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int k = 0; k < NUM_COMP; k++) begin
                look_tag_q[k] <= look_tag[k];
            end
        end
    end

    // invalid entries read as miss with zero direction and usefulness
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q  <= '0;
            pred_q <= '0;
            for (int k = 0; k < NUM_COMP; k++) begin
                u_q[k] <= 2'b00;
            end
        end else if (!stall) begin
            for (int k = 0; k < NUM_COMP; k++) begin
                hit_q[k]  <= rv[k] && (rd[k][TE_TAG_LSB +: TAG_W] == look_tag_q[k]);
                pred_q[k] <= rv[k] & rd[k][TE_DIR_BIT];
                u_q[k]    <= rv[k] ? rd[k][TE_U_LSB +: 2] : 2'b00;
            end
        end
    end

    assign usable = hit_q & {u_q[2][1], u_q[1][1], u_q[0][1]};

    // longest usable wins, previous winner becomes the alternate
    always_comb begin
        prov       = 2'd0;
        pred_taken = base_taken;
        alt_taken  = base_taken;
        for (int k = 0; k < NUM_COMP; k++) begin
            if (usable[k]) begin
                alt_taken  = pred_taken;
                pred_taken = pred_q[k];
                prov       = provider_t'(k + 1);
            end
        end
    end

    always_comb begin
        pred_meta = '0;
        pred_meta[META_ALT_BIT] = alt_taken;
        pred_meta[META_PROV_LSB +: 2] = prov;
        for (int k = 0; k < NUM_COMP; k++) begin
            pred_meta[META_PRED_LSB + k] = pred_q[k];
            pred_meta[META_U_LSB + 2*k +: 2] = u_q[k];
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_COMP; k++) begin
            m_pred[k] = upd_meta[META_PRED_LSB + k];
            m_u[k]    = upd_meta[META_U_LSB + 2*k +: 2];
        end
        m_prov = upd_meta[META_PROV_LSB +: 2];
        m_alt  = upd_meta[META_ALT_BIT];
    end

    assign m_slot = m_prov - 2'd1;

    always_comb begin
        logic found;
        found   = 1'b0;
        we      = '0;
        new_dir = m_pred;
        new_u   = m_u;
        if (upd_valid) begin
            if (upd_pred_taken == upd_taken) begin
                // reward only when the alternate would have been wrong
                if (m_alt != upd_pred_taken && m_prov != 2'd0) begin
                    we[m_slot]    = 1'b1;
                    new_u[m_slot] = sat_step(m_u[m_slot], 1'b1);
                end
            end else begin
                if (m_prov != 2'd0) begin
                    we[m_slot]    = 1'b1;
                    new_u[m_slot] = sat_step(m_u[m_slot], 1'b0);
                end
                // allocate in the shortest free component
                for (int k = 0; k < NUM_COMP; k++) begin
                    if (!found && m_u[k] == 2'b00) begin
                        found      = 1'b1;
                        we[k]      = 1'b1;
                        new_u[k]   = 2'b10;
                        new_dir[k] = upd_taken;
                    end
                end
                // nothing free, age everyone
                if (!found) begin
                    for (int k = 0; k < NUM_COMP; k++) begin
                        we[k]    = 1'b1;
                        new_u[k] = sat_step(m_u[k], 1'b0);
                    end
                end
            end
        end
    end

    assign we0    = we[0];
    assign we1    = we[1];
    assign we2    = we[2];
    assign wdata0 = {new_dir[0], upd_tag[0], new_u[0]};
    assign wdata1 = {new_dir[1], upd_tag[1], new_u[1]};
    assign wdata2 = {new_dir[2], upd_tag[2], new_u[2]};

endmodule

// ==== verif/bp_assert.sv ====
// protocol and selection assertions for the branch predictor top
`timescale 1ns/1ps
module bp_assert (
    input logic          clk,
    input logic          arst_n,
    input logic          stall,
    input logic          upd_valid,
    input logic          we0,
    input logic          we1,
    input logic          we2,
    input logic          pred_taken,
    input bp_pkg::meta_t pred_meta,
    input logic          base_taken,
    input logic [2:0]    usable
);
    import bp_pkg::*;

    no_write_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !upd_valid |-> !(we0 || we1 || we2))
        else $error("table write without a resolve");

    outputs_hold_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> ($stable(pred_taken) && $stable(pred_meta)))
        else $error("prediction changed while stalled");

    // nothing usable means the base counter decides
    base_when_none_usable: assert property (@(posedge clk) disable iff (!arst_n)
        (usable == 3'b000) |-> (pred_meta[META_PROV_LSB +: 2] == 2'd0
                                && pred_taken == base_taken))
        else $error("provider set with no usable component");

endmodule

bind branch_predictor_top bp_assert bp_checks (
    .clk(clk), .arst_n(arst_n), .stall(stall), .upd_valid(upd_valid),
    .we0(we0), .we1(we1), .we2(we2),
    .pred_taken(pred_taken), .pred_meta(pred_meta),
    .base_taken(base_taken), .usable(tage.usable)
);

// ==== verif/bp_model.svh ====
// reference model of the predictor tables, hashes and update policy
logic        m_valid [3][256];
logic        m_dir   [3][256];
logic [11:0] m_tag   [3][256];
logic [1:0]  m_u     [3][256];
logic [1:0]  m_ctr   [256];

function automatic int hist_len_of(input int k);
    if (k == 0) begin
        return HIST_LEN_0;
    end else if (k == 1) begin
        return HIST_LEN_1;
    end
    return HIST_LEN_2;
endfunction

// each history bit lands on bit (i mod width) of the index or tag
function automatic idx_t calc_index(input pc_t p, input ghist_t g, input int k);
    idx_t r;
    r = p[7:0];
    for (int i = 0; i < hist_len_of(k); i++) begin
        r[i % 8] = r[i % 8] ^ g[i];
    end
    return r;
endfunction

function automatic tag_t calc_tag(input pc_t p, input ghist_t g, input int k);
    tag_t r;
    r = p[19:8];
    for (int i = 0; i < hist_len_of(k); i++) begin
        r[i % 12] = r[i % 12] ^ g[i];
    end
    return r;
endfunction

function automatic ctr2_t ctr_inc(input ctr2_t c);
    return (c == 2'b11) ? c : c + 2'd1;
endfunction

function automatic ctr2_t ctr_dec(input ctr2_t c);
    return (c == 2'b00) ? c : c - 2'd1;
endfunction

task automatic model_reset();
    for (int i = 0; i < 256; i++) begin
        m_ctr[i] = 2'b01;
        for (int k = 0; k < 3; k++) begin
            m_valid[k][i] = 1'b0;
            m_dir[k][i]   = 1'b0;
            m_tag[k][i]   = '0;
            m_u[k][i]     = 2'b00;
        end
    end
endtask

task automatic model_predict(input pc_t p, input ghist_t g,
                             output logic taken, output meta_t meta);
    idx_t      ix;
    logic      hit [3];
    logic      pd [3];
    ctr2_t     u [3];
    logic      alt;
    provider_t prov;
    for (int k = 0; k < 3; k++) begin
        ix     = calc_index(p, g, k);
        hit[k] = m_valid[k][ix] && (m_tag[k][ix] == calc_tag(p, g, k));
        pd[k]  = m_valid[k][ix] && m_dir[k][ix];
        u[k]   = m_valid[k][ix] ? m_u[k][ix] : 2'b00;
    end
    taken = m_ctr[p[7:0]][1];
    alt   = taken;
    prov  = 2'd0;
    for (int k = 0; k < 3; k++) begin
        if (hit[k] && u[k][1]) begin
            alt   = taken;
            taken = pd[k];
            prov  = provider_t'(k + 1);
        end
    end
    meta = {alt, prov, u[2], u[1], u[0], pd[2], pd[1], pd[0]};
endtask

task automatic model_resolve(input pc_t p, input ghist_t g, input logic taken,
                             input logic ptaken, input meta_t meta);
    logic      wr [3];
    logic      nd [3];
    ctr2_t     ou [3];
    ctr2_t     nu [3];
    provider_t prov;
    logic      alt;
    logic      found;
    idx_t      ix;
    prov  = meta[10:9];
    alt   = meta[11];
    found = 1'b0;
    for (int k = 0; k < 3; k++) begin
        wr[k] = 1'b0;
        nd[k] = meta[k];
        ou[k] = meta[3 + 2*k +: 2];
        nu[k] = ou[k];
    end
    if (ptaken == taken) begin
        if (prov != 2'd0 && alt != ptaken) begin
            wr[prov - 1] = 1'b1;
            nu[prov - 1] = ctr_inc(ou[prov - 1]);
        end
    end else begin
        if (prov != 2'd0) begin
            wr[prov - 1] = 1'b1;
            nu[prov - 1] = ctr_dec(ou[prov - 1]);
        end
        for (int k = 0; k < 3; k++) begin
            if (!found && ou[k] == 2'b00) begin
                found = 1'b1;
                wr[k] = 1'b1;
                nu[k] = 2'b10;
                nd[k] = taken;
            end
        end
        if (!found) begin
            for (int k = 0; k < 3; k++) begin
                wr[k] = 1'b1;
                nu[k] = ctr_dec(ou[k]);
            end
        end
    end
    for (int k = 0; k < 3; k++) begin
        if (wr[k]) begin
            ix             = calc_index(p, g, k);
            m_valid[k][ix] = 1'b1;
            m_dir[k][ix]   = nd[k];
            m_tag[k][ix]   = calc_tag(p, g, k);
            m_u[k][ix]     = nu[k];
        end
    end
    m_ctr[p[7:0]] = taken ? ctr_inc(m_ctr[p[7:0]]) : ctr_dec(m_ctr[p[7:0]]);
endtask

// ==== verif/bp_tb.sv ====
// testbench for the branch direction predictor against a reference model
`timescale 1ns/1ps
module bp_tb;
    import bp_pkg::*;

    localparam int  NUM_TESTS    = 6;
    localparam int  CYC_PER_TEST = 160;
    localparam real CLK_NS       = 4.0;
    localparam real TIMEOUT_NS   = NUM_TESTS * CYC_PER_TEST * CLK_NS;

    logic   clk;
    logic   arst_n;
    logic   stall;
    pc_t    pc;
    ghist_t gh;
    logic   pred_taken;
    meta_t  pred_meta;
    logic   upd_valid;
    pc_t    upd_pc;
    ghist_t upd_gh;
    logic   upd_taken;
    logic   upd_pred_taken;
    meta_t  upd_meta;

    `include "bp_model.svh"

    branch_predictor_top dut0 (
        .clk(clk), .arst_n(arst_n), .stall(stall), .pc(pc), .gh(gh),
        .pred_taken(pred_taken), .pred_meta(pred_meta),
        .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_gh(upd_gh),
        .upd_taken(upd_taken), .upd_pred_taken(upd_pred_taken), .upd_meta(upd_meta)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests completed");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    task automatic check_bit(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %b expected %b", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_meta(input meta_t got, input meta_t exp, input string what);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_field(input logic [1:0] got, input logic [1:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    function automatic pc_t rand_pc();
        logic [31:0] r;
        r = $urandom;
        return r[PC_W-1:0];
    endfunction

    // entered one ns after a rising edge, leaves at the same phase
    task automatic lookup(input pc_t p, input ghist_t g,
                          output logic exp_taken, output meta_t exp_meta);
        model_predict(p, g, exp_taken, exp_meta);
        pc    = p;
        gh    = g;
        stall = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        check_bit(pred_taken, exp_taken, "pred_taken");
        check_meta(pred_meta, exp_meta, "pred_meta");
    endtask

    task automatic resolve(input pc_t p, input ghist_t g, input logic taken,
                           input logic ptaken, input meta_t meta);
        upd_valid      = 1'b1;
        upd_pc         = p;
        upd_gh         = g;
        upd_taken      = taken;
        upd_pred_taken = ptaken;
        upd_meta       = meta;
        model_resolve(p, g, taken, ptaken, meta);
        @(posedge clk);
        #1;
        upd_valid = 1'b0;
    endtask

    task automatic test_reset_state();
        logic  t;
        meta_t m;
        for (int i = 0; i < 4; i++) begin
            lookup(rand_pc(), $urandom, t, m);
            check_bit(pred_taken, 1'b0, "reset pred_taken");
            check_field(pred_meta[10:9], 2'd0, "reset provider");
        end
    endtask

    task automatic test_base_training();
        pc_t    p;
        ghist_t g;
        logic   t;
        meta_t  m;
        p = rand_pc();
        g = $urandom;
        lookup(p, g, t, m);
        // resolved as correctly predicted, so only the base counter moves
        resolve(p, g, 1'b1, 1'b1, m);
        resolve(p, g, 1'b1, 1'b1, m);
        lookup(p, g, t, m);
        check_bit(pred_taken, 1'b1, "trained taken");
        check_field(pred_meta[10:9], 2'd0, "base provider");
        resolve(p, g, 1'b0, 1'b0, m);
        resolve(p, g, 1'b0, 1'b0, m);
        lookup(p, g, t, m);
        check_bit(pred_taken, 1'b0, "retrained not-taken");
    endtask

    // shared by the allocation, history and usefulness tests
    pc_t    a_pc;
    ghist_t a_gh;

    task automatic test_allocation();
        logic  t;
        meta_t m;
        a_pc = rand_pc();
        a_gh = $urandom;
        lookup(a_pc, a_gh, t, m);
        resolve(a_pc, a_gh, ~t, t, m);
        lookup(a_pc, a_gh, t, m);
        check_field(pred_meta[10:9], 2'd1, "alloc provider");
        check_field(pred_meta[4:3], 2'b10, "alloc usefulness");
    endtask

    task automatic test_longer_history();
        logic  t;
        logic  short_dir;
        meta_t m;
        lookup(a_pc, a_gh, t, m);
        short_dir = t;
        // base-only resolves turn the base counter against the short entry
        repeat (2) begin
            resolve(a_pc, a_gh, ~short_dir, ~short_dir, '0);
        end
        lookup(a_pc, a_gh, t, m);
        check_bit(pred_meta[11], ~short_dir, "base alternate");
        // correct with a differing alternate raises u0 to 11
        resolve(a_pc, a_gh, t, t, m);
        lookup(a_pc, a_gh, t, m);
        check_field(pred_meta[4:3], 2'b11, "u0 raised");
        resolve(a_pc, a_gh, ~t, t, m);
        lookup(a_pc, a_gh, t, m);
        check_field(pred_meta[10:9], 2'd2, "longer provider");
        check_bit(pred_taken, ~short_dir, "longer direction");
        check_bit(pred_meta[11], short_dir, "alternate bit");
    endtask

    task automatic test_usefulness();
        logic  t;
        meta_t m;
        lookup(a_pc, a_gh, t, m);
        resolve(a_pc, a_gh, t, t, m);
        lookup(a_pc, a_gh, t, m);
        check_field(pred_meta[6:5], 2'b11, "u1 raised");
        resolve(a_pc, a_gh, ~t, t, m);
        lookup(a_pc, a_gh, t, m);
        check_field(pred_meta[6:5], 2'b10, "u1 lowered");
        check_field(pred_meta[10:9], 2'd3, "third provider");
        // no free component left
        resolve(a_pc, a_gh, ~t, t, m);
        lookup(a_pc, a_gh, t, m);
        check_field(pred_meta[4:3], 2'b01, "u0 aged");
        check_field(pred_meta[6:5], 2'b01, "u1 aged");
        check_field(pred_meta[8:7], 2'b01, "u2 aged");
    endtask

    task automatic test_stall();
        logic   t;
        logic   held_t;
        meta_t  m;
        meta_t  held_m;
        pc_t    p;
        ghist_t g;
        lookup(a_pc, a_gh, held_t, held_m);
        p     = rand_pc();
        g     = $urandom;
        stall = 1'b1;
        pc    = p;
        gh    = g;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_bit(pred_taken, held_t, "stalled pred_taken");
            check_meta(pred_meta, held_m, "stalled pred_meta");
        end
        lookup(p, g, t, m);
    endtask

    initial begin
        void'($urandom(32'haf1955be));
        arst_n         = 1'b0;
        stall          = 1'b0;
        pc             = '0;
        gh             = '0;
        upd_valid      = 1'b0;
        upd_pc         = '0;
        upd_gh         = '0;
        upd_taken      = 1'b0;
        upd_pred_taken = 1'b0;
        upd_meta       = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset_state();
        test_base_training();
        test_allocation();
        test_longer_history();
        test_usefulness();
        test_stall();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
